// File: Bender.yml
package:
  name: analog_top

sources:
  - logic/rp_pkg.sv
  - logic/sys_bus_decoder.sv
  - logic/hk_regs.sv
  - logic/adc_frontend.sv
  - logic/dac_output.sv
  - logic/ams_regs.sv
  - logic/pwm_bank.sv
  - logic/analog_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/analog_top_tb.sv

// File: logic/adc_frontend.sv
// adc input stage
// registers the 14 usable bits of each raw adc word, converts
// the negative slope code to two's complement and swaps in
// the dac stream while the digital loop is on

`timescale 1ns/1ps

module adc_frontend import rp_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  // raw converter bus
  input  logic [ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [ADC_RAW_W-1:0] adc_dat_b_i,
  // loopback
  input  logic                 digital_loop_i,
  input  sample_t              dac_sat_a_i,
  input  sample_t              dac_sat_b_i,
  // converted samples
  output sample_t              adc_a_o,
  output sample_t              adc_b_o
);

  logic [SAMPLE_W-1:0] raw_a_q;  // input registers, neg slope code
  logic [SAMPLE_W-1:0] raw_b_q;
  sample_t             conv_a;   // after slope conversion
  sample_t             conv_b;

  ////////////////////
  // input registers
  ////////////////////

  // lowest 2 bits reserved, dropped here
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end
    else
    begin
      raw_a_q <= adc_dat_a_i[ADC_RAW_W-1:ADC_RAW_W-SAMPLE_W];
      raw_b_q <= adc_dat_b_i[ADC_RAW_W-1:ADC_RAW_W-SAMPLE_W];
    end
  end

  // neg slope unsigned -> two's complement
  assign conv_a = sample_t'(slope_flip(raw_a_q));
  assign conv_b = sample_t'(slope_flip(raw_b_q));

  // loop mux, dac sum passes through in the same cycle
  assign adc_a_o = digital_loop_i ? dac_sat_a_i : conv_a;
  assign adc_b_o = digital_loop_i ? dac_sat_b_i : conv_b;

endmodule

// File: logic/ams_regs.sv
// analog mixed signal registers
// one pwm duty word per channel, starting at AMS_DUTY_OFS
// with a 4 byte stride. duty lives in the low 8 bits

`timescale 1ns/1ps

module ams_regs import rp_pkg::*;
#(
  parameter int unsigned CH_NUM = 4
)(
  input  logic                          adc_clk,
  input  logic                          rst_n_i,
  // system bus, region 4
  input  logic [SYS_AW-1:0]             sys_addr_i,
  input  logic [SYS_DW-1:0]             sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [SYS_DW-1:0]             sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o,
  // duty values to the pwm bank
  output logic [CH_NUM-1:0][PWM_W-1:0]  duty_o
);

  logic [19:0]                    ofs;      // offset inside the region
  logic [CH_NUM-1:0][PWM_W-1:0]   duty_q;
  logic                           ack_q;
  logic [SYS_DW-1:0]              rdata_q;

  assign ofs = sys_addr_i[19:0];

  ////////////////////
  // duty registers
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      duty_q <= '0;  // all outputs low
      ack_q  <= 1'b0;
    end
    else
    begin
      ack_q <= sys_wen_i | sys_ren_i;
      for (int ch = 0; ch < CH_NUM; ch++)
        if (sys_wen_i && ofs == 20'(AMS_DUTY_OFS + 4*ch))
          duty_q[ch] <= sys_wdata_i[PWM_W-1:0];  // upper bits ignored
    end
  end

  // read back, zero above the duty and on unmapped offsets
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      rdata_q <= '0;
      for (int ch = 0; ch < CH_NUM; ch++)
        if (ofs == 20'(AMS_DUTY_OFS + 4*ch))
          rdata_q <= SYS_DW'(duty_q[ch]);
    end
  end

  assign sys_rdata_o = rdata_q;
  assign sys_ack_o   = ack_q;
  assign sys_err_o   = 1'b0;
  assign duty_o      = duty_q;

endmodule

// File: logic/analog_top.sv
// analog front end top level
// bus decoder, housekeeping and ams register blocks,
// adc input stage with digital loop, dac output stage
// and the pwm bank, all on adc_clk

`timescale 1ns/1ps

module analog_top import rp_pkg::*;
#(
  parameter logic [SYS_DW-1:0] HK_ID  = 32'h0,
  parameter int unsigned       CH_NUM = 4
)(
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  // system bus
  input  logic [SYS_AW-1:0]    sys_addr_i,
  input  logic [SYS_DW-1:0]    sys_wdata_i,
  input  logic                 sys_wen_i,
  input  logic                 sys_ren_i,
  output logic [SYS_DW-1:0]    sys_rdata_o,
  output logic                 sys_ack_o,
  output logic                 sys_err_o,
  // converters and streams
  input  logic [ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [ADC_RAW_W-1:0] adc_dat_b_i,
  input  sample_t              asg_a_i,
  input  sample_t              asg_b_i,
  input  sample_t              pid_a_i,
  input  sample_t              pid_b_i,
  output sample_t              adc_a_o,
  output sample_t              adc_b_o,
  output logic [SAMPLE_W-1:0]  dac_a_o,
  output logic [SAMPLE_W-1:0]  dac_b_o,
  output logic [CH_NUM-1:0]    pwm_o
);

  logic                         hk_wen, hk_ren, hk_ack, hk_err;
  logic                         ams_wen, ams_ren, ams_ack, ams_err;
  logic [SYS_DW-1:0]            hk_rdata, ams_rdata;
  logic                         digital_loop;
  sample_t                      dac_sat_a, dac_sat_b;
  logic [CH_NUM-1:0][PWM_W-1:0] duty;

  ////////////////////
  // bus and registers
  ////////////////////

  sys_bus_decoder i_dec (
    .adc_clk     (adc_clk),     .rst_n_i   (rst_n_i),
    .sys_addr_i  (sys_addr_i),  .sys_wen_i (sys_wen_i),  .sys_ren_i (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o (sys_ack_o),  .sys_err_o (sys_err_o),
    .hk_wen_o    (hk_wen),      .hk_ren_o  (hk_ren),
    .hk_rdata_i  (hk_rdata),    .hk_ack_i  (hk_ack),     .hk_err_i  (hk_err),
    .ams_wen_o   (ams_wen),     .ams_ren_o (ams_ren),
    .ams_rdata_i (ams_rdata),   .ams_ack_i (ams_ack),    .ams_err_i (ams_err)
  );

  hk_regs #(.HK_ID(HK_ID)) i_hk (
    .adc_clk     (adc_clk),     .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (hk_wen),      .sys_ren_i   (hk_ren),
    .sys_rdata_o (hk_rdata),    .sys_ack_o   (hk_ack),  .sys_err_o (hk_err),
    .digital_loop_o (digital_loop)
  );

  ams_regs #(.CH_NUM(CH_NUM)) i_ams (
    .adc_clk     (adc_clk),     .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (ams_wen),     .sys_ren_i   (ams_ren),
    .sys_rdata_o (ams_rdata),   .sys_ack_o   (ams_ack), .sys_err_o (ams_err),
    .duty_o      (duty)
  );

  ////////////////////
  // data paths
  ////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),      .rst_n_i     (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),  .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_sat_a_i    (dac_sat_a),    .dac_sat_b_i (dac_sat_b),
    .adc_a_o        (adc_a_o),      .adc_b_o     (adc_b_o)
  );

  dac_output i_dac (
    .adc_clk     (adc_clk),    .rst_n_i     (rst_n_i),
    .asg_a_i     (asg_a_i),    .asg_b_i     (asg_b_i),
    .pid_a_i     (pid_a_i),    .pid_b_i     (pid_b_i),
    .dac_sat_a_o (dac_sat_a),  .dac_sat_b_o (dac_sat_b),  // loop source
    .dac_a_o     (dac_a_o),    .dac_b_o     (dac_b_o)
  );

  pwm_bank #(.CH_NUM(CH_NUM)) i_pwm (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .duty_i  (duty),
    .pwm_o   (pwm_o)
  );

endmodule

// File: logic/dac_output.sv
// dac output stage
// adds generator and controller streams per channel,
// saturates the sum to 14 bits and registers its
// negative slope offset code for the converter

`timescale 1ns/1ps

module dac_output import rp_pkg::*;
(
  input  logic                adc_clk,
  input  logic                rst_n_i,
  // streams to add
  input  sample_t             asg_a_i,
  input  sample_t             asg_b_i,
  input  sample_t             pid_a_i,
  input  sample_t             pid_b_i,
  // saturated sums, to the loop mux
  output sample_t             dac_sat_a_o,
  output sample_t             dac_sat_b_o,
  // converter code
  output logic [SAMPLE_W-1:0] dac_a_o,
  output logic [SAMPLE_W-1:0] dac_b_o
);

  logic signed [SAMPLE_W:0] sum_a;  // one guard bit
  logic signed [SAMPLE_W:0] sum_b;
  logic [SAMPLE_W-1:0]      dac_a_q;
  logic [SAMPLE_W-1:0]      dac_b_q;

  // clip to -8192..8191 when the two top bits disagree
  function automatic sample_t saturate(input logic signed [SAMPLE_W:0] sum);
    if (sum[SAMPLE_W] != sum[SAMPLE_W-1])
      return {sum[SAMPLE_W], {(SAMPLE_W-1){~sum[SAMPLE_W]}}};
    return sum[SAMPLE_W-1:0];
  endfunction

  ////////////////////
  // sum and clip
  ////////////////////

  assign sum_a = asg_a_i + pid_a_i;  // signed, extended to 15 bits
  assign sum_b = asg_b_i + pid_b_i;

  assign dac_sat_a_o = saturate(sum_a);
  assign dac_sat_b_o = saturate(sum_b);

  // output registers, 0x1fff is mid scale
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_a_q <= {1'b0, {(SAMPLE_W-1){1'b1}}};
      dac_b_q <= {1'b0, {(SAMPLE_W-1){1'b1}}};
    end
    else
    begin
      dac_a_q <= slope_flip(dac_sat_a_o);
      dac_b_q <= slope_flip(dac_sat_b_o);
    end
  end

  assign dac_a_o = dac_a_q;
  assign dac_b_o = dac_b_q;

endmodule

// File: logic/hk_regs.sv
// housekeeping registers
// id word (read only) and the digital loop enable.
// ack follows the strobe by one cycle

`timescale 1ns/1ps

module hk_regs import rp_pkg::*;
#(
  parameter logic [SYS_DW-1:0] HK_ID = 32'h0
)(
  input  logic              adc_clk,
  input  logic              rst_n_i,
  // system bus, region 0
  input  logic [SYS_AW-1:0] sys_addr_i,
  input  logic [SYS_DW-1:0] sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output logic [SYS_DW-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  // configuration
  output logic              digital_loop_o
);

  logic [19:0]       ofs;      // offset inside the region
  logic              loop_q;   // loop enable bit
  logic              ack_q;
  logic [SYS_DW-1:0] rdata_q;

  assign ofs = sys_addr_i[19:0];

  ////////////////////
  // control registers
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      loop_q <= 1'b0;
      ack_q  <= 1'b0;
    end
    else
    begin
      ack_q <= sys_wen_i | sys_ren_i;  // one cycle after strobe
      if (sys_wen_i && ofs == HK_LOOP_OFS[19:0])
        loop_q <= sys_wdata_i[0];
    end
  end

  // read data, unmapped offsets give 0
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (ofs)
        HK_ID_OFS[19:0]:   rdata_q <= HK_ID;
        HK_LOOP_OFS[19:0]: rdata_q <= {{(SYS_DW-1){1'b0}}, loop_q};
        default:           rdata_q <= '0;
      endcase
    end
  end

  assign sys_rdata_o    = rdata_q;
  assign sys_ack_o      = ack_q;
  assign sys_err_o      = 1'b0;    // nothing here can fail
  assign digital_loop_o = loop_q;

endmodule

// File: logic/pwm_bank.sv
// pwm output bank
// one free running 8 bit counter shared by all channels,
// each output high while the counter is below its duty,
// so duty d gives d high cycles out of 256

`timescale 1ns/1ps

module pwm_bank import rp_pkg::*;
#(
  parameter int unsigned CH_NUM = 4
)(
  input  logic                         adc_clk,
  input  logic                         rst_n_i,
  input  logic [CH_NUM-1:0][PWM_W-1:0] duty_i,
  output logic [CH_NUM-1:0]            pwm_o
);

  logic [PWM_W-1:0]  cnt_q;  // period counter, wraps at 256
  logic [CH_NUM-1:0] pwm_q;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      cnt_q <= '0;
      pwm_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
      for (int ch = 0; ch < CH_NUM; ch++)
        pwm_q[ch] <= (cnt_q < duty_i[ch]);  // new duty picked up at once
    end
  end

  assign pwm_o = pwm_q;  // registered, glitch free

endmodule

// File: logic/rp_pkg.sv
// analog front end shared definitions
// widths, sample type, bus regions and register offsets
// plus the negative slope code conversion used on both converters

package rp_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int unsigned SAMPLE_W  = 14;  // converter sample
  localparam int unsigned ADC_RAW_W = 16;  // raw adc bus, 2 lsb reserved
  localparam int unsigned SYS_AW    = 32;  // system bus address
  localparam int unsigned SYS_DW    = 32;  // system bus data
  localparam int unsigned REGION_N  = 8;   // regions on addr[22:20]
  localparam int unsigned PWM_W     = 8;   // pwm duty value

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement sample

  // bus regions, indices kept from the full system map
  typedef enum logic [2:0] {
    REG_HK    = 3'd0,  // housekeeping
    REG_FREE1 = 3'd1,
    REG_FREE2 = 3'd2,
    REG_FREE3 = 3'd3,
    REG_AMS   = 3'd4,  // analog mixed signals
    REG_FREE5 = 3'd5,
    REG_FREE6 = 3'd6,
    REG_FREE7 = 3'd7
  } region_e;

  ////////////////////
  // register offsets
  ////////////////////

  localparam logic [SYS_AW-1:0] HK_ID_OFS    = 32'h00;  // id word, read only
  localparam logic [SYS_AW-1:0] HK_LOOP_OFS  = 32'h04;  // digital loop enable
  localparam logic [SYS_AW-1:0] AMS_DUTY_OFS = 32'h20;  // duty of ch0, +4 per ch

  // negative slope code <-> two's complement, msb kept, rest inverted
  // same operation in both directions
  function automatic logic [SAMPLE_W-1:0] slope_flip(input logic [SAMPLE_W-1:0] code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};
  endfunction

endpackage

// File: logic/sys_bus_decoder.sv
// system bus decoder
// splits the address space into eight regions on addr[22:20],
// fans the strobes out to the selected block and merges the replies.
// unused regions answer in the strobe cycle with zero data

`timescale 1ns/1ps

module sys_bus_decoder import rp_pkg::*;
(
  input  logic              adc_clk,
  input  logic              rst_n_i,
  // bus from outside
  input  logic [SYS_AW-1:0] sys_addr_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output logic [SYS_DW-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  // housekeeping block
  output logic              hk_wen_o,
  output logic              hk_ren_o,
  input  logic [SYS_DW-1:0] hk_rdata_i,
  input  logic              hk_ack_i,
  input  logic              hk_err_i,
  // ams block
  output logic              ams_wen_o,
  output logic              ams_ren_o,
  input  logic [SYS_DW-1:0] ams_rdata_i,
  input  logic              ams_ack_i,
  input  logic              ams_err_i
);

  region_e             region;    // decoded from current address
  region_e             region_q;  // region of the open transfer
  region_e             sel;       // region whose reply goes back
  logic [REGION_N-1:0] cs;        // one-hot chip select
  logic                pend_q;    // transfer open on a registered block

  assign region = region_e'(sys_addr_i[22:20]);
  assign cs     = {{(REGION_N-1){1'b0}}, 1'b1} << region;

  // strobe fan-out
  assign hk_wen_o  = sys_wen_i & cs[REG_HK];
  assign hk_ren_o  = sys_ren_i & cs[REG_HK];
  assign ams_wen_o = sys_wen_i & cs[REG_AMS];
  assign ams_ren_o = sys_ren_i & cs[REG_AMS];

  ////////////////////
  // transfer tracking
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      pend_q   <= 1'b0;
      region_q <= REG_HK;
    end
    else if (hk_wen_o | hk_ren_o | ams_wen_o | ams_ren_o)
    begin
      pend_q   <= 1'b1;    // block acks next cycle
      region_q <= region;
    end
    else if (sys_ack_o)
      pend_q <= 1'b0;      // done
  end

  assign sel = pend_q ? region_q : region;

  // reply merge
  always_comb
  begin
    sys_rdata_o = '0;
    sys_ack_o   = 1'b0;
    sys_err_o   = 1'b0;
    case (sel)
      REG_HK:
      begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = pend_q & hk_ack_i;  // only acks of our own transfer
        sys_err_o   = pend_q & hk_err_i;
      end
      REG_AMS:
      begin
        sys_rdata_o = ams_rdata_i;
        sys_ack_o   = pend_q & ams_ack_i;
        sys_err_o   = pend_q & ams_err_i;
      end
      default: sys_ack_o = sys_wen_i | sys_ren_i;  // free region, same cycle
    endcase
  end

endmodule

// File: project.f
+incdir+verif
logic/rp_pkg.sv
logic/sys_bus_decoder.sv
logic/hk_regs.sv
logic/adc_frontend.sv
logic/dac_output.sv
logic/ams_regs.sv
logic/pwm_bank.sv
logic/analog_top.sv
verif/analog_top_tb.sv

// File: verif/tb_bus_tasks.svh
// bus transfer tasks, random source and reference models
// for the analog front end testbench, included inside the
// testbench module and working on its signals

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

  ////////////////////
  // random source
  ////////////////////

  // galois lfsr, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ({1'b0, s[31:1]} ^ 32'hB4BC_D35C) : {1'b0, s[31:1]};
  endfunction

  // n fresh bits, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return r;
  endfunction

  ////////////////////
  // reference models
  ////////////////////

  // code 0 is full positive scale, one lsb down per code step
  function automatic sample_t adc_to_sample(input logic [15:0] raw);
    int code;
    code = int'(raw[15:2]);   // reserved bits gone
    return sample_t'(8191 - code);
  endfunction

  function automatic sample_t clip_sum(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return sample_t'(s);
  endfunction

  // offset code for the dac, zero sits at 0x1fff
  function automatic logic [13:0] dac_code(input sample_t a, input sample_t b);
    int s;
    s = int'(clip_sum(a, b));
    return 14'(8191 - s);
  endfunction

  ////////////////////
  // bus transfers
  ////////////////////

  // one cycle strobe, address and data held until ack
  task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] data, input logic wr);
    logic acked;
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = wr;
    sys_ren   = !wr;
    @(posedge adc_clk);
    acked = sys_ack;            // free regions ack right away
    #2;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    while (!acked)
    begin
      @(posedge adc_clk);
      acked = sys_ack;
      #2;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    bus_xfer(addr, data, 1'b1);
  endtask

  // expected data goes to the read assertion
  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
    rd_expect = exp;
    rd_check  = 1'b1;
    bus_xfer(addr, 32'h0, 1'b0);
    rd_check  = 1'b0;
  endtask

`endif

// File: verif/analog_top_tb.sv
// testbench for the analog front end top level
// drives bus, raw adc words and dac streams from an lfsr,
// concurrent assertions compare every response with the
// reference models of the bus task header

`timescale 1ns/1ps

module analog_top_tb import rp_pkg::*;
();

  localparam logic [31:0] HK_ID     = 32'h5250_0A01;
  localparam int          CH_NUM    = 4;
  localparam logic [31:0] HK_BASE   = 32'h4000_0000;  // region 0
  localparam logic [31:0] AMS_BASE  = 32'h4040_0000;  // region 4
  localparam logic [31:0] FREE_BASE = 32'h4050_0000;  // unused region 5
  localparam int          N_ADC     = 200;
  localparam int          N_DAC     = 200;
  localparam int          N_LOOP    = 100;
  localparam int          PWM_WIN   = 256;
  // reset, bus, streams, two pwm rounds and some slack
  localparam int LIMIT = 16 + 60 + N_ADC + N_DAC + 6 + 2 * N_LOOP + 10
                       + 2 * (20 + 3 * PWM_WIN) + 200;

  logic              adc_clk = 1'b0;
  logic              rst_n   = 1'b0;
  logic [31:0]       sys_addr, sys_wdata, sys_rdata;
  logic              sys_wen, sys_ren, sys_ack, sys_err;
  logic [15:0]       adc_dat_a, adc_dat_b;
  sample_t           asg_a, asg_b, pid_a, pid_b;
  sample_t           adc_a, adc_b;
  logic [13:0]       dac_a, dac_b;
  logic [CH_NUM-1:0] pwm;

  string       test_name = "reset";
  int          errors    = 0;
  int          err_mark  = 0;
  int          n_tests   = 0;
  int          cycles    = 0;
  int          fill      = 0;           // cycles of pwm history
  logic [31:0] lfsr      = 32'h3aa04f10;
  logic [31:0] rd_expect = '0;
  logic        rd_check  = 1'b0;
  logic        adc_chk   = 1'b0;
  logic        dac_chk   = 1'b0;
  logic        loop_chk  = 1'b0;
  logic        pwm_chk   = 1'b0;
  logic        adc_valid = 1'b0;        // adc_chk one cycle late
  logic        dac_valid = 1'b0;
  logic        rst_seen  = 1'b0;
  logic [15:0] raw_a_d, raw_b_d;        // last cycle's inputs
  sample_t     asg_a_d, asg_b_d, pid_a_d, pid_b_d;
  sample_t     exp_adc_a, exp_adc_b, loop_a, loop_b;
  logic [13:0] exp_dac_a, exp_dac_b;
  logic [255:0] hist [CH_NUM];          // last 256 pwm samples
  logic [8:0]   hi_cnt [CH_NUM];
  logic [7:0]   duty_exp [CH_NUM];

  `include "tb_bus_tasks.svh"

  analog_top #(.HK_ID(HK_ID), .CH_NUM(CH_NUM)) DUT (
    .adc_clk     (adc_clk),    .rst_n_i     (rst_n),
    .sys_addr_i  (sys_addr),   .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),  .sys_ack_o   (sys_ack),  .sys_err_o (sys_err),
    .adc_dat_a_i (adc_dat_a),  .adc_dat_b_i (adc_dat_b),
    .asg_a_i     (asg_a),      .asg_b_i     (asg_b),
    .pid_a_i     (pid_a),      .pid_b_i     (pid_b),
    .adc_a_o     (adc_a),      .adc_b_o     (adc_b),
    .dac_a_o     (dac_a),      .dac_b_o     (dac_b),
    .pwm_o       (pwm)
  );

  always #20 adc_clk = ~adc_clk;  // 40 ns period

  ////////////////////
  // expected values
  ////////////////////

  always @(posedge adc_clk)
  begin
    rst_seen  <= !rst_n;
    adc_valid <= adc_chk;
    dac_valid <= dac_chk;
    raw_a_d   <= adc_dat_a;
    raw_b_d   <= adc_dat_b;
    asg_a_d   <= asg_a;
    asg_b_d   <= asg_b;
    pid_a_d   <= pid_a;
    pid_b_d   <= pid_b;
    fill      <= pwm_chk ? fill + 1 : 0;
    for (int ch = 0; ch < CH_NUM; ch++)
      hist[ch] <= {hist[ch][254:0], pwm[ch]};
  end

  assign exp_adc_a = adc_to_sample(raw_a_d);
  assign exp_adc_b = adc_to_sample(raw_b_d);
  assign exp_dac_a = dac_code(asg_a_d, pid_a_d);
  assign exp_dac_b = dac_code(asg_b_d, pid_b_d);
  assign loop_a    = clip_sum(asg_a, pid_a);    // same cycle in loop mode
  assign loop_b    = clip_sum(asg_b, pid_b);

  task automatic mismatch(input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("Fail %s: expected %h, actual %h", test_name, exp, act);
  endtask

  task automatic fault(input string msg);
    errors++;
    $display("%s: %s", test_name, msg);
  endtask

  ////////////////////
  // assertions
  ////////////////////

  read_ok: assert property (@(posedge adc_clk) disable iff (!rst_n)
    (sys_ack && rd_check) |-> sys_rdata == rd_expect)
    else mismatch($sampled(rd_expect), $sampled(sys_rdata));
  no_err: assert property (@(posedge adc_clk) disable iff (!rst_n) sys_ack |-> !sys_err)
    else fault("bus error flag set on a transfer");
  ack_pulse: assert property (@(posedge adc_clk) disable iff (!rst_n) sys_ack |=> !sys_ack)
    else fault("ack held for more than one cycle");
  dac_rst: assert property (@(posedge adc_clk)
    (!rst_n && rst_seen) |-> {dac_a, dac_b} == {2{14'h1fff}})
    else mismatch({2{14'h1fff}}, $sampled({dac_a, dac_b}));
  adc_ok: assert property (@(posedge adc_clk) disable iff (!rst_n)
    adc_valid |-> {adc_a, adc_b} == {exp_adc_a, exp_adc_b})
    else mismatch($sampled({exp_adc_a, exp_adc_b}), $sampled({adc_a, adc_b}));
  dac_ok: assert property (@(posedge adc_clk) disable iff (!rst_n)
    dac_valid |-> {dac_a, dac_b} == {exp_dac_a, exp_dac_b})
    else mismatch($sampled({exp_dac_a, exp_dac_b}), $sampled({dac_a, dac_b}));
  loop_ok: assert property (@(posedge adc_clk) disable iff (!rst_n)
    loop_chk |-> {adc_a, adc_b} == {loop_a, loop_b})
    else mismatch($sampled({loop_a, loop_b}), $sampled({adc_a, adc_b}));

  // high count over every full 256 cycle window
  for (genvar ch = 0; ch < CH_NUM; ch++)
  begin : g_pwm
    assign hi_cnt[ch] = 9'($countones(hist[ch]));
    duty_ok: assert property (@(posedge adc_clk) disable iff (!rst_n)
      (pwm_chk && fill >= PWM_WIN) |-> hi_cnt[ch] == 9'(duty_exp[ch]))
      else mismatch(32'(duty_exp[ch]), 32'($sampled(hi_cnt[ch])));
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic step_clock(input int n);
    repeat (n)
    begin
      @(posedge adc_clk);
      #2;
    end
  endtask

  task automatic drive_random();
    adc_dat_a = 16'(rand_bits(16));
    adc_dat_b = 16'(rand_bits(16));
    asg_a     = sample_t'(rand_bits(14));
    asg_b     = sample_t'(rand_bits(14));
    pid_a     = sample_t'(rand_bits(14));
    pid_b     = sample_t'(rand_bits(14));
    step_clock(1);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    n_tests++;
    if (errors == err_mark)
      $display("test %s done, no errors", test_name);
    else
      $display("test %s done, %0d errors", test_name, errors - err_mark);
  endtask

  task automatic pwm_round(input logic [CH_NUM-1:0][7:0] duty);
    for (int ch = 0; ch < CH_NUM; ch++)
    begin
      duty_exp[ch] = duty[ch];
      bus_write(AMS_BASE + AMS_DUTY_OFS + 32'(4 * ch), {24'h0, duty[ch]});
    end
    step_clock(PWM_WIN);       // one full period to settle
    pwm_chk = 1'b1;
    step_clock(2 * PWM_WIN);   // fill the window, then slide it
    pwm_chk = 1'b0;
  endtask

  // run limit
  always @(posedge adc_clk)
  begin
    cycles <= cycles + 1;
    if (cycles > LIMIT)
    begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    int          ext_a [6];
    int          ext_b [6];
    logic [31:0] word;
    ext_a     = '{8191, -8192, 8191, 8191, -8192, 0};   // saturating pairs
    ext_b     = '{8191, -8192, -8192, 1, -1, 0};
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    asg_a     = sample_t'(1000);    // nonzero, reset must win
    asg_b     = sample_t'(-1000);
    pid_a     = '0;
    pid_b     = '0;
    repeat (16) @(posedge adc_clk);
    #2;
    rst_n = 1'b1;
    end_test();

    start_test("regs");
    bus_read(HK_BASE + HK_ID_OFS, HK_ID);
    bus_write(HK_BASE + HK_LOOP_OFS, 32'h1);
    bus_read(HK_BASE + HK_LOOP_OFS, 32'h1);
    bus_write(HK_BASE + HK_LOOP_OFS, 32'h0);
    bus_read(HK_BASE + HK_LOOP_OFS, 32'h0);
    for (int ch = 0; ch < CH_NUM; ch++)
    begin
      word         = rand_bits(32);     // upper bits must be dropped
      duty_exp[ch] = word[7:0];
      bus_write(AMS_BASE + AMS_DUTY_OFS + 32'(4 * ch), word);
    end
    for (int ch = 0; ch < CH_NUM; ch++)
      bus_read(AMS_BASE + AMS_DUTY_OFS + 32'(4 * ch), 32'(duty_exp[ch]));
    step_clock(1);                      // gap, free region acks at once
    bus_read(FREE_BASE, 32'h0);
    end_test();

    start_test("adc");
    adc_chk = 1'b1;
    repeat (N_ADC) drive_random();
    adc_chk = 1'b0;
    step_clock(2);
    end_test();

    start_test("dac");
    dac_chk = 1'b1;
    for (int i = 0; i < 6; i++)
    begin
      asg_a = sample_t'(ext_a[i]);
      pid_a = sample_t'(ext_b[i]);
      asg_b = sample_t'(ext_b[i]);
      pid_b = sample_t'(ext_a[i]);
      step_clock(1);
    end
    repeat (N_DAC) drive_random();
    dac_chk = 1'b0;
    step_clock(2);
    end_test();

    start_test("loop");
    bus_write(HK_BASE + HK_LOOP_OFS, 32'h1);
    loop_chk = 1'b1;
    repeat (N_LOOP) drive_random();
    loop_chk = 1'b0;
    bus_write(HK_BASE + HK_LOOP_OFS, 32'h0);
    adc_chk = 1'b1;                     // back on the adc input
    repeat (N_LOOP) drive_random();
    adc_chk = 1'b0;
    step_clock(2);
    end_test();

    start_test("pwm");
    word = rand_bits(16);
    pwm_round({word[15:0], 8'd255, 8'd0});
    pwm_round(rand_bits(32));
    end_test();

    step_clock(2);
    $display("%0d tests run, %0d checks failed", n_tests, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
